// File: vlog.f
verilog/uart_timing_pkg.sv
verilog/uart_frame_pkg.sv
verilog/uart_rx_if.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart.sv
tests/uart_properties.sv
tests/uart_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the uart testbench with verilator, run it and check the log
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
rm -f "$LOG"

# compile design, bound assertions and testbench
verilator --binary --timing --assert \
	-f vlog.f \
	--top-module uart_tb

# run, keeping a copy of the output for the verdict search
./obj_dir/Vuart_tb | tee "$LOG"

# the verdict comes from the log
if grep -qF '** PASS **' "$LOG"; then
	echo "simulation passed"
	exit 0
else
	echo "simulation failed, see $LOG"
	exit 1
fi

// File: tests/uart_tb.sv
// uart testbench
`timescale 1ns/100ps
`default_nettype none

module uart_tb
	import uart_timing_pkg::*;
	import uart_frame_pkg::*;
();

	// -------------------------------------------------------------------
	// run length
	// -------------------------------------------------------------------
	localparam int N_TX     = 20;                      // random transmit frames
	localparam int N_BUSY   = 2;                       // frames hit by a send while busy
	localparam int N_RX     = 20;                      // random receive frames
	localparam int N_FAULT  = 2;                       // bad stop frame, frame after glitch
	localparam int N_LOOP   = 10;                      // loopback frames
	localparam int N_FRAMES = N_TX + N_BUSY + N_RX + N_FAULT + N_LOOP;
	localparam int FRAME_CYCLES   = FRAME_BITS * BIT_CYCLES;
	localparam int TIMEOUT_CYCLES = N_FRAMES * FRAME_CYCLES * 2 + 200;

	logic       clk;
	logic       rst_n;
	logic       send;
	uart_byte_t tx_data;
	logic       tx_busy;
	logic       txd;
	logic       rxd;
	logic       rxd_drv;                               // line from the serial model
	logic       loopback;                              // rxd follows txd
	uart_byte_t rx_data;
	logic       rx_valid;
	logic       rx_busy;
	logic       rx_frame_err;

	integer     seed;                                  // $random state
	int         errors;
	int         cycles;
	int         tx_sent;                               // accepted sends
	int         tx_seen;                               // frames decoded on txd
	uart_byte_t tx_exp[$];                             // bytes due on txd
	uart_byte_t rx_exp_data[$];                        // bytes due on rx_data
	logic       rx_exp_err[$];                         // matching frame_err

	assign rxd = loopback ? txd : rxd_drv;

	uart dut (
		.clk          (clk),
		.rst_n        (rst_n),
		.send         (send),
		.tx_data      (tx_data),
		.tx_busy      (tx_busy),
		.txd          (txd),
		.rxd          (rxd),
		.rx_data      (rx_data),
		.rx_valid     (rx_valid),
		.rx_busy      (rx_busy),
		.rx_frame_err (rx_frame_err)
	);

	always #10 clk = ~clk;                             // 20 ns period

	// -------------------------------------------------------------------
	// helpers
	// -------------------------------------------------------------------
	task automatic check_byte(input string name, input uart_byte_t exp, input uart_byte_t got);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic note_error(input string what);
		errors++;
		$display("error: %s", what);
	endtask

	task automatic step();
		@(posedge clk);
		#2;                                            // drive point after the edge
	endtask

	task automatic step_cycles(input int n);
		repeat (n) step();
	endtask

	task automatic send_byte(input uart_byte_t b);
		tx_data = b;
		send    = 1'b1;                                // one cycle strobe
		step();
		send    = 1'b0;
	endtask

	// start, 8 data lsb first, stop, BIT_CYCLES each
	task automatic drive_frame(input uart_byte_t b, input logic stop);
		rxd_drv = 1'b0;
		step_cycles(BIT_CYCLES);
		for (int i = 0; i < DATA_BITS; i++) begin
			rxd_drv = b[i];
			step_cycles(BIT_CYCLES);
		end
		rxd_drv = stop;
		step_cycles(BIT_CYCLES);
		rxd_drv = 1'b1;                                // back to idle
	endtask

	task automatic expect_rx_done(input string what);
		if (rx_exp_data.size() != 0) begin
			note_error({"missing rx_valid for ", what});
			rx_exp_data.delete();
			rx_exp_err.delete();
		end
	endtask

	// -------------------------------------------------------------------
	// monitors and timeout
	// -------------------------------------------------------------------
	initial begin : txd_monitor
		uart_byte_t got;
		uart_byte_t exp;
		wait (rst_n === 1'b1);
		forever begin
			@(negedge clk);
			if (txd === 1'b0) begin                    // start edge seen
				repeat (HALF_BIT) @(negedge clk);      // middle of start bit
				check_bit("txd start bit", 1'b0, txd);
				for (int i = 0; i < DATA_BITS; i++) begin
					repeat (BIT_CYCLES) @(negedge clk);
					got[i] = txd;                      // lsb first
				end
				repeat (BIT_CYCLES) @(negedge clk);
				check_bit("txd stop bit", 1'b1, txd);
				tx_seen++;
				if (tx_exp.size() == 0) begin
					note_error("frame on txd without an accepted send");
				end else begin
					exp = tx_exp.pop_front();
					check_byte("txd data", exp, got);
				end
			end
		end
	end

	initial begin : rx_monitor
		uart_byte_t exp_data;
		logic       exp_err;
		forever begin
			@(negedge clk);                            // outputs settled
			if (rst_n === 1'b1 && rx_valid === 1'b1) begin
				if (rx_exp_data.size() == 0) begin
					note_error("rx_valid pulse with no frame expected");
				end else begin
					exp_data = rx_exp_data.pop_front();
					exp_err  = rx_exp_err.pop_front();
					check_byte("rx_data", exp_data, rx_data);
					check_bit("rx_frame_err", exp_err, rx_frame_err);
				end
			end
		end
	end

	initial begin : watchdog
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: run did not finish in %0d cycles, %0d errors so far",
			cycles, errors);
		$display("** FAIL **");
		$finish;
	end

	// -------------------------------------------------------------------
	// stimulus
	// -------------------------------------------------------------------
	initial begin
		int         len;
		uart_byte_t b;
		clk      = 1'b0;
		rst_n    = 1'b0;
		send     = 1'b0;
		tx_data  = '0;
		rxd_drv  = 1'b1;                               // idle line
		loopback = 1'b0;
		seed     = 95;
		errors   = 0;
		cycles   = 0;
		tx_sent  = 0;
		tx_seen  = 0;
		repeat (4) @(posedge clk);
		#2 rst_n = 1'b1;

		// reset state
		check_bit("txd", 1'b1, txd);
		check_bit("tx_busy", 1'b0, tx_busy);
		check_bit("rx_busy", 1'b0, rx_busy);
		check_bit("rx_valid", 1'b0, rx_valid);
		check_bit("rx_frame_err", 1'b0, rx_frame_err);
		check_byte("rx_data", '0, rx_data);

		// transmit with random gaps and busy lasting one frame
		for (int n = 0; n < N_TX; n++) begin
			step_cycles($random(seed) & 7);
			b = uart_byte_t'($random(seed));
			tx_exp.push_back(b);
			send_byte(b);
			tx_sent++;
			len = 0;
			while (tx_busy === 1'b1) begin
				step();
				len++;
			end
			if (len != FRAME_CYCLES) begin
				errors++;
				$display("[FAIL] tx_busy length: expected %h, got %h", FRAME_CYCLES, len);
			end
		end

		// send while busy is dropped
		for (int n = 0; n < N_BUSY; n++) begin
			b = uart_byte_t'($random(seed));
			tx_exp.push_back(b);
			send_byte(b);
			tx_sent++;
			step_cycles(3 * BIT_CYCLES);               // well inside the frame
			check_bit("tx_busy", 1'b1, tx_busy);
			send_byte(~b);
			while (tx_busy === 1'b1) step();
		end
		step_cycles(BIT_CYCLES);
		if (tx_seen != tx_sent)
			note_error($sformatf("%0d frames on txd for %0d accepted sends", tx_seen, tx_sent));

		// receive clean frames
		for (int n = 0; n < N_RX; n++) begin
			b = uart_byte_t'($random(seed));
			rx_exp_data.push_back(b);
			rx_exp_err.push_back(1'b0);
			drive_frame(b, 1'b1);
			step_cycles(BIT_CYCLES + ($random(seed) & 7));
			expect_rx_done("a clean frame");
		end

		// stop bit forced low
		b = uart_byte_t'($random(seed));
		rx_exp_data.push_back(b);
		rx_exp_err.push_back(1'b1);
		drive_frame(b, 1'b0);
		step_cycles(2 * BIT_CYCLES);                   // false start after it aborts
		expect_rx_done("a frame with a low stop bit");

		// short low glitch, then a real frame
		rxd_drv = 1'b0;
		step_cycles(HALF_BIT - 2);
		rxd_drv = 1'b1;
		step_cycles(2 * BIT_CYCLES);
		check_bit("rx_busy", 1'b0, rx_busy);
		b = uart_byte_t'($random(seed));
		rx_exp_data.push_back(b);
		rx_exp_err.push_back(1'b0);
		drive_frame(b, 1'b1);
		step_cycles(2 * BIT_CYCLES);
		expect_rx_done("the frame after a glitch");

		// loopback with each next send landing on the edge the stop bit ends
		loopback = 1'b1;
		step_cycles(2);
		for (int n = 0; n < N_LOOP; n++) begin
			b = uart_byte_t'($random(seed));
			tx_exp.push_back(b);
			rx_exp_data.push_back(b);
			rx_exp_err.push_back(1'b0);
			send_byte(b);
			tx_sent++;
			if (n < N_LOOP - 1)
				step_cycles(FRAME_CYCLES - 1);
		end
		while (tx_busy === 1'b1) step();
		step_cycles(2 * BIT_CYCLES);
		expect_rx_done("a loopback frame");
		if (tx_seen != tx_sent)
			note_error($sformatf("%0d frames on txd for %0d accepted sends", tx_seen, tx_sent));
		if (tx_exp.size() != 0)
			note_error("accepted bytes never appeared on txd");

		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/uart_properties.sv
// uart protocol assertions
`timescale 1ns/100ps
`default_nettype none

module uart_properties
	import uart_timing_pkg::*;
(
	input logic clk,
	input logic rst_n,
	input logic busy,   // frame in progress
	input logic txd,    // serial out, tied high on the receive side
	input logic valid   // result pulse, tied low on the transmit side
);

	// -------------------------------------------------------------------
	// reset and idle line
	// -------------------------------------------------------------------
	busy_after_reset: assert property (
		@(posedge clk) !rst_n |=> !busy               // reset clears any frame
	) else $error("busy high on the cycle after reset");

	idle_line_high: assert property (
		@(posedge clk) disable iff (!rst_n) !busy |-> txd
	) else $error("txd low while the transmitter is idle");

	// shortest frame is an aborted start bit, half a bit long
	busy_min_len: assert property (
		@(posedge clk) disable iff (!rst_n) $rose(busy) |-> busy[*HALF_BIT]
	) else $error("busy shorter than half a bit");

	// -------------------------------------------------------------------
	// result pulse
	// -------------------------------------------------------------------
	valid_one_cycle: assert property (
		@(posedge clk) disable iff (!rst_n) valid |=> !valid
	) else $error("valid longer than one cycle");

	valid_ends_frame: assert property (
		@(posedge clk) disable iff (!rst_n) valid |-> $fell(busy)  // same edge as busy falls
	) else $error("valid without busy falling");

endmodule

bind uart_tx uart_properties tx_checks (
	.clk   (clk),
	.rst_n (rst_n),
	.busy  (busy),
	.txd   (txd),
	.valid (1'b0)          // no result pulse on this side
);

bind uart_rx uart_properties rx_checks (
	.clk   (clk),
	.rst_n (rst_n),
	.busy  (res.busy),
	.txd   (1'b1),         // no serial output here
	.valid (res.valid)
);

`default_nettype wire

// File: verilog/uart.sv
// uart top level
`timescale 1ns/100ps
`default_nettype none

module uart
	import uart_frame_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,

	// transmit side
	input  logic       send,          // strobe, taken when idle
	input  uart_byte_t tx_data,       // byte for the next frame
	output logic       tx_busy,       // frame going out
	output logic       txd,           // serial out

	// receive side
	input  logic       rxd,           // serial in
	output uart_byte_t rx_data,       // last received byte
	output logic       rx_valid,      // one cycle per frame
	output logic       rx_busy,       // frame coming in
	output logic       rx_frame_err   // stop bit was low
);

	// -------------------------------------------------------------------
	// receiver results bundle
	// -------------------------------------------------------------------
	uart_rx_if rx_res ();

	// -------------------------------------------------------------------
	// transmitter
	// -------------------------------------------------------------------
	uart_tx u_tx (
		.clk   (clk),
		.rst_n (rst_n),
		.data  (tx_data),
		.send  (send),
		.busy  (tx_busy),
		.txd   (txd)
	);

	// -------------------------------------------------------------------
	// receiver
	// -------------------------------------------------------------------
	uart_rx u_rx (
		.clk   (clk),
		.rst_n (rst_n),
		.rxd   (rxd),
		.res   (rx_res)
	);

	// sink side of the bundle onto plain ports
	assign rx_data      = rx_res.data;
	assign rx_valid     = rx_res.valid;
	assign rx_busy      = rx_res.busy;
	assign rx_frame_err = rx_res.frame_err;

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
// uart receiver
`timescale 1ns/100ps
`default_nettype none

module uart_rx
	import uart_timing_pkg::*;
	import uart_frame_pkg::*;
(
	input  logic     clk,
	input  logic     rst_n,
	input  logic     rxd,   // serial in, idle high
	uart_rx_if.source res    // received byte and status
);

	// -------------------------------------------------------------------
	// state
	// -------------------------------------------------------------------
	logic       rxd_q;     // one register stage on the line
	logic       active;    // frame in progress
	bit_idx_t   pos;       // START_POS..STOP_POS, next sample
	div_cnt_t   div_cnt;   // cycles to next sample
	uart_byte_t shreg;     // data bits, lsb arrives first

	logic tick;       // sample point reached
	logic at_start;   // this sample is the start bit
	logic at_stop;    // this sample is the stop bit
	logic shift_en;   // data bit sample

	assign tick     = active && (div_cnt == '0);
	assign at_start = (pos == START_POS);
	assign at_stop  = (pos == STOP_POS);
	assign shift_en = tick && !at_start && !at_stop;

	// -------------------------------------------------------------------
	// frame control
	// -------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rxd_q         <= 1'b1;                     // no false start out of reset
			active        <= 1'b0;
			pos           <= START_POS;
			div_cnt       <= '0;
			res.data      <= '0;
			res.valid     <= 1'b0;
			res.frame_err <= 1'b0;
		end else begin
			rxd_q     <= rxd;
			res.valid <= 1'b0;                         // pulse by default off
			if (!active) begin
				if (!rxd_q) begin                      // falling edge seen
					active  <= 1'b1;
					pos     <= START_POS;
					div_cnt <= HALF_LOAD;              // aim at mid start bit
				end
			end else if (!tick) begin
				div_cnt <= div_cnt - div_cnt_t'(1);
			end else begin
				div_cnt <= BIT_LOAD;                   // one bit to next middle
				if (at_start) begin
					if (rxd_q) begin
						active <= 1'b0;                // glitch, back to idle
					end else begin
						pos <= pos + bit_idx_t'(1);
					end
				end else if (at_stop) begin
					active        <= 1'b0;             // busy falls with valid
					res.data      <= shreg;
					res.valid     <= 1'b1;
					res.frame_err <= !rxd_q;           // stop must be high
				end else begin
					pos <= pos + bit_idx_t'(1);        // next data bit
				end
			end
		end
	end

	// -------------------------------------------------------------------
	// data shifter
	// -------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (shift_en) begin
			shreg <= {rxd_q, shreg[DATA_BITS-1:1]};    // lsb first, ends aligned
		end
	end

	assign res.busy = active;

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
// uart transmitter
`timescale 1ns/100ps
`default_nettype none

module uart_tx
	import uart_timing_pkg::*;
	import uart_frame_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  uart_byte_t data,  // byte to send, taken with send
	input  logic       send,  // start strobe
	output logic       busy,  // frame on the line
	output logic       txd    // serial out, idle high
);

	// -------------------------------------------------------------------
	// state
	// -------------------------------------------------------------------
	logic [FRAME_BITS-1:0] shreg;    // stop, data, start; lsb on the line
	bit_idx_t              pos;      // 0 idle, 1..FRAME_BITS current bit
	div_cnt_t              div_cnt;  // cycles left in current bit

	logic tick;      // bit time over
	logic last_bit;  // stop bit on the line
	logic take;      // send accepted this edge

	assign tick     = (div_cnt == '0);
	assign last_bit = (pos == TX_LAST);

	// idle, or the edge where the stop bit ends, so frames can run back to back
	assign take = send && (!busy || (tick && last_bit));

	// -------------------------------------------------------------------
	// shifter and bit timer
	// -------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			shreg   <= '1;                             // line idles high
			pos     <= '0;
			div_cnt <= '0;
		end else if (take) begin
			shreg   <= {1'b1, data, 1'b0};             // stop, byte, start
			pos     <= bit_idx_t'(1);                  // start bit now
			div_cnt <= BIT_LOAD;
		end else if (busy) begin
			if (tick) begin
				shreg   <= {1'b1, shreg[FRAME_BITS-1:1]}; // next bit, fill with idle
				div_cnt <= BIT_LOAD;                   // reload timer
				if (last_bit) begin
					pos <= '0;                         // frame done
				end else begin
					pos <= pos + bit_idx_t'(1);
				end
			end else begin
				div_cnt <= div_cnt - div_cnt_t'(1);   // count down
			end
		end
	end

	// -------------------------------------------------------------------
	// outputs
	// -------------------------------------------------------------------
	assign busy = (pos != '0);                         // any position means active
	assign txd  = shreg[0];                            // all ones once frame shifted out

endmodule

`default_nettype wire

// File: verilog/uart_rx_if.sv
// uart receiver result bundle
`timescale 1ns/100ps
`default_nettype none

interface uart_rx_if import uart_frame_pkg::*; ();

	// -------------------------------------------------------------------
	// result signals of one received frame
	// -------------------------------------------------------------------
	uart_byte_t data;      // last byte, held until next frame ends
	logic       valid;     // one cycle pulse per completed frame
	logic       busy;      // frame in progress
	logic       frame_err; // stop bit was low, updated with valid

	// receiver side drives everything
	modport source (
		output data,
		output valid,
		output busy,
		output frame_err
	);

	// consumer side only reads
	modport sink (
		input data,
		input valid,
		input busy,
		input frame_err
	);

endinterface

`default_nettype wire

// File: verilog/uart_frame_pkg.sv
// uart frame format definitions
`default_nettype none

package uart_frame_pkg;

	// -------------------------------------------------------------------
	// frame of start, 8 data lsb first and stop with no parity
	// -------------------------------------------------------------------
	localparam int DATA_BITS  = 8;                     // payload width
	localparam int FRAME_BITS = 10;                    // start + data + stop

	typedef logic [DATA_BITS-1:0] uart_byte_t;        // one payload byte
	typedef logic [3:0]           bit_idx_t;          // frame position, 0..FRAME_BITS

	// positions within the frame as counted by the receiver
	localparam bit_idx_t START_POS = bit_idx_t'(0);              // start bit check
	localparam bit_idx_t STOP_POS  = bit_idx_t'(FRAME_BITS - 1); // stop bit sample

	// transmitter counts from 1, so the last bit has index FRAME_BITS
	localparam bit_idx_t TX_LAST   = bit_idx_t'(FRAME_BITS);

endpackage

`default_nettype wire

// File: verilog/uart_timing_pkg.sv
// uart bit timing constants
`default_nettype none

package uart_timing_pkg;

	// -------------------------------------------------------------------
	// clock and line rate
	// -------------------------------------------------------------------
	localparam int CLK_HZ = 1_000_000;                 // system clock
	localparam int BAUD   = 125_000;                   // serial line rate

	// -------------------------------------------------------------------
	// bit timer
	// -------------------------------------------------------------------
	localparam int BIT_CYCLES = CLK_HZ / BAUD;         // clocks per bit, 8
	localparam int HALF_BIT   = BIT_CYCLES / 2;        // start edge to mid start bit
	localparam int DIV_W      = $clog2(BIT_CYCLES) + 1; // timer width, one spare bit

	typedef logic [DIV_W-1:0] div_cnt_t;               // down-counting bit timer

	// timer preloads that expire on the edge after the timer reads zero
	localparam div_cnt_t BIT_LOAD  = div_cnt_t'(BIT_CYCLES - 1); // full bit
	localparam div_cnt_t HALF_LOAD = div_cnt_t'(HALF_BIT - 1);   // half bit

endpackage

`default_nettype wire
